//--- fm_extend_datapath.f
fm_extend_pkg.sv
seed_entry_stage.sv
ctx_delay_line.sv
extend_resolve.sv
fm_extend_datapath.sv
fm_extend_properties.sv
fm_extend_datapath_tb.sv

//--- fm_extend_datapath_tb.sv
module fm_extend_datapath_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fm_extend_pkg::*;

	localparam logic [CNT_W-1:0] PRIMARY = 64'h0000_0000_8000_0000; // $ row of the index
	localparam int N_RAND   = 200;
	localparam int N_DIRECT = 10;
	localparam int N_DRAINS = 4;
	localparam int ITEMS    = N_RAND + N_DIRECT + 17 * N_DRAINS; // bubbles count too
	localparam int LIMIT    = 4 * (ITEMS + 17) + 200;
	localparam int OFS_RES  = OCC_LATENCY;     // curr write and ret
	localparam int OFS_QRY  = OCC_LATENCY + 2; // query request
	localparam int OFS_OUT  = OCC_LATENCY + 3; // dram and ctx_o

	typedef struct packed {
		occ_req_t   req;
		logic       curr_we;
		curr_wr_t   curr_wr;
		logic       ret_valid;
		ret_t       ret;
		query_req_t query;
		logic       dram_valid;
		dram_req_t  dram;
		seed_ctx_t  ctx;
	} expect_t;

	logic             Clk_32UI = 1'b0;
	logic             reset_BWT_extend;
	logic             stall_i;
	logic [CNT_W-1:0] primary_i;
	seed_ctx_t        ctx_i;
	fm_interval_t     occ_rsp_i;
	occ_req_t         occ_req_o;
	logic             curr_we_o;
	curr_wr_t         curr_wr_o;
	logic             ret_valid_o;
	ret_t             ret_o;
	query_req_t       query_o;
	logic             dram_valid_o;
	dram_req_t        dram_o;
	seed_ctx_t        ctx_o;

	fm_interval_t  occ_pipe [OCC_LATENCY]; // engine model latency
	expect_t       exp_mem [4096];
	int            edge_mem [4096];        // advancing edge that samples the item
	int            wr_ptr, h_req, h_res, h_qry, h_out;
	int            adv_cnt, cyc, err_cnt, chk_cnt, tests, bad_tests;
	logic          last_adv;
	logic [1023:0] snap, cur;
	logic [31:0]   rng = 32'had3d4a43;

	fm_extend_datapath uut (.*);

	always #2 Clk_32UI = ~Clk_32UI; // 4 ns period

	//------------------------------------------------------------
	// helpers
	//------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// engine stand-in, k[3:2] picks how the interval moves
	function automatic fm_interval_t occ_model(input logic [CNT_W-1:0] k, l);
		fm_interval_t r;
		case (k[3:2])
			2'd0:    r.x2 = l - k;                  // usually unchanged
			2'd1:    r.x2 = l - k + 64'd5;          // grows
			2'd2:    r.x2 = {58'd0, k[9:4]};        // tiny, breaks
			default: r.x2 = (l - k) >> 1;
		endcase
		r.x1 = l + (k >> 3);
		r.x0 = k ^ 64'h5a5a_5a5a_5a5a_5a5a;
		return r;
	endfunction

	function automatic expect_t ref_model(input seed_ctx_t c);
		expect_t          e;
		seed_ctx_t        s;
		fm_interval_t     rsp;
		status_t          st0;
		logic [CNT_W-1:0] k, l, kb, lb;
		e = '0;
		k = c.ik.x1 - 64'd1;
		l = k + c.ik.x2;
		if (k >= PRIMARY) k = k - 64'd1; // primary skip on both
		if (l >= PRIMARY) l = l - 64'd1;
		e.req.k = k;
		e.req.l = l;
		rsp = occ_model(k, l);
		s = c;
		if (s.status == F_RUN && s.forward_i >= LEN) s.status = F_BREAK; // Len limit
		e.curr_wr.read_num = s.read_num;
		e.curr_wr.addr     = s.ptr_curr;
		e.curr_wr.data     = {s.ik_info, s.ik.x2, s.ik.x1, s.ik.x0};
		st0 = s.status;
		if (st0 == F_RUN && rsp.x2 != s.ik.x2) begin
			e.curr_we  = 1'b1;
			s.ptr_curr = s.ptr_curr + 1'b1;
			if (rsp.x2 < {57'd0, s.min_intv}) s.status = F_BREAK;
		end
		if (st0 == F_BREAK) begin
			if (s.forward_i == LEN) begin
				e.curr_we  = 1'b1;
				s.ptr_curr = s.ptr_curr + 1'b1;
			end
			e.ret_valid    = 1'b1;
			e.ret.read_num = s.read_num;
			e.ret.ret      = s.ik_info[POS_W-1:0];
			s.status       = BCK_INI;
		end
		if (s.status == F_RUN) begin // extension taken
			s.ik        = rsp;
			s.ik_info   = {57'd0, s.forward_i} + 64'd1;
			s.forward_i = s.forward_i + 1'b1;
		end
		e.query.status   = s.status;
		e.query.read_num = s.read_num;
		e.query.pos      = s.forward_i;
		kb = s.ik.x1 - 64'd1;
		lb = kb + s.ik.x2;
		if (kb >= PRIMARY) kb = kb - 64'd1;
		if (lb >= PRIMARY) lb = lb - 64'd1;
		if (s.status == F_INIT || s.status == F_RUN) begin
			e.dram_valid  = 1'b1;
			e.dram.addr_k = {kb[34:7], 4'b0};
			e.dram.addr_l = {lb[34:7], 4'b0};
		end
		if (s.status == F_INIT) s.status = F_RUN;
		e.ctx = s;
		return e;
	endfunction

	function automatic seed_ctx_t mk_ctx(input status_t st, input logic [5:0] rn,
			input logic [6:0] ptr, input logic [63:0] x1, x2, info,
			input logic [6:0] fwd, mn);
		seed_ctx_t c;
		c.status    = st;
		c.read_num  = rn;
		c.ptr_curr  = ptr;
		c.ik.x1     = x1;
		c.ik.x2     = x2;
		c.ik.x0     = x1 ^ 64'h0f0f_0000_0000_1234;
		c.ik_info   = info;
		c.forward_i = fwd;
		c.min_intv  = mn;
		return c;
	endfunction

	task automatic check_value(input string what, input logic [1023:0] got, exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic drive(input seed_ctx_t c, input logic st);
		@(negedge Clk_32UI);
		stall_i = st;
		ctx_i   = c;
		if (!st) begin
			exp_mem[wr_ptr]  = ref_model(c);
			edge_mem[wr_ptr] = adv_cnt + 1;
			wr_ptr++;
		end
	endtask

	task automatic drain_and_report(input string name, input int err0);
		int target;
		target = wr_ptr; // last item of this test
		while (h_out < target) drive('0, 1'b0); // bubbles push the rest out
		tests++;
		if (err_cnt != err0) bad_tests++;
		$display("test %s: %0d errors", name, err_cnt - err0);
	endtask

	//------------------------------------------------------------
	// occurrence engine model, shifts only on advancing edges
	//------------------------------------------------------------
	always @(negedge Clk_32UI) begin
		if (last_adv) begin
			for (int i = OCC_LATENCY - 1; i > 0; i--) occ_pipe[i] = occ_pipe[i-1];
			occ_pipe[0] = occ_model(occ_req_o.k, occ_req_o.l);
			occ_rsp_i   = occ_pipe[OCC_LATENCY-1];
		end
	end

	//------------------------------------------------------------
	// compare, 1 ns after each rising edge
	//------------------------------------------------------------
	always @(posedge Clk_32UI) begin
		#1;
		last_adv = !stall_i;
		cur = {occ_req_o, curr_we_o, curr_wr_o, ret_valid_o, ret_o, query_o,
			dram_valid_o, dram_o, ctx_o};
		if (!reset_BWT_extend) begin
			check_value("strobes in reset", {curr_we_o, ret_valid_o, dram_valid_o}, '0);
		end
		else if (!last_adv) begin
			check_value("outputs held under stall", cur, snap);
		end
		else begin
			adv_cnt++;
			if (h_req < wr_ptr && edge_mem[h_req] == adv_cnt) begin
				check_value("occ_req_o", occ_req_o, exp_mem[h_req].req);
				h_req++;
			end
			if (h_res < wr_ptr && edge_mem[h_res] + OFS_RES == adv_cnt) begin
				check_value("curr_we_o", curr_we_o, exp_mem[h_res].curr_we);
				check_value("curr_wr_o", curr_wr_o, exp_mem[h_res].curr_wr);
				check_value("ret_valid_o", ret_valid_o, exp_mem[h_res].ret_valid);
				check_value("ret_o", ret_o, exp_mem[h_res].ret);
				h_res++;
			end
			if (h_qry < wr_ptr && edge_mem[h_qry] + OFS_QRY == adv_cnt) begin
				check_value("query_o", query_o, exp_mem[h_qry].query);
				h_qry++;
			end
			if (h_out < wr_ptr && edge_mem[h_out] + OFS_OUT == adv_cnt) begin
				check_value("dram_valid_o", dram_valid_o, exp_mem[h_out].dram_valid);
				check_value("dram_o", dram_o, exp_mem[h_out].dram);
				check_value("ctx_o", ctx_o, exp_mem[h_out].ctx);
				h_out++;
			end
		end
		snap = cur;
	end

	always @(posedge Clk_32UI) begin
		cyc++;
		if (cyc >= LIMIT) begin
			$display("run timed out after %0d cycles with results still missing", cyc);
			$display("sim failed");
			$finish;
		end
	end

	//------------------------------------------------------------
	// stimulus
	//------------------------------------------------------------
	initial begin
		int        e0;
		seed_ctx_t c;
		reset_BWT_extend = 1'b0;
		stall_i   = 1'b0;
		primary_i = PRIMARY;
		ctx_i     = '0;
		occ_rsp_i = '0;
		last_adv  = 1'b0;
		for (int i = 0; i < OCC_LATENCY; i++) occ_pipe[i] = '0;
		{wr_ptr, h_req, h_res, h_qry, h_out, adv_cnt, cyc} = '0;
		{err_cnt, chk_cnt, tests, bad_tests} = '0;

		e0 = err_cnt;
		repeat (4) @(posedge Clk_32UI); // reset for 4 cycles
		@(negedge Clk_32UI);
		reset_BWT_extend = 1'b1;
		repeat (3) begin
			@(negedge Clk_32UI);
			check_value("strobes after reset", {curr_we_o, ret_valid_o, dram_valid_o}, '0);
		end
		tests++;
		if (err_cnt != e0) bad_tests++;
		$display("test reset: %0d errors", err_cnt - e0);

		e0 = err_cnt;
		drive(mk_ctx(F_INIT, 6'd3, 7'd5, 64'h9000_0101, 64'h300, 64'd0, 7'd0, 7'd10), 1'b0);
		drive(mk_ctx(F_INIT, 6'd4, 7'd0, 64'h1000_0011, 64'h2345, 64'd0, 7'd0, 7'd10), 1'b0);
		drain_and_report("f_init", e0);

		e0 = err_cnt;
		drive(mk_ctx(F_RUN, 6'd7, 7'd9, 64'h1005, 64'h100, 64'd30, 7'd30, 7'd20), 1'b0);
		drive(mk_ctx(F_RUN, 6'd8, 7'd2, 64'h1001, 64'h100, 64'd12, 7'd12, 7'd20), 1'b0);
		drive(mk_ctx(F_RUN, 6'd9, 7'd4, 64'h8000_0006, 64'h80, 64'd50, 7'd50, 7'd3), 1'b0);
		drain_and_report("f_run", e0);

		e0 = err_cnt;
		drive(mk_ctx(F_RUN, 6'd10, 7'd1, 64'h1009, 64'h100, 64'd40, 7'd40, 7'd20), 1'b0);
		drive(mk_ctx(F_RUN, 6'd11, 7'd6, 64'h1005, 64'h100, 64'd100, 7'd101, 7'd2), 1'b0);
		drive(mk_ctx(F_RUN, 6'd12, 7'd6, 64'h1005, 64'h100, 64'd100, 7'd120, 7'd2), 1'b0);
		drive(mk_ctx(F_BREAK, 6'd13, 7'd8, 64'h2000, 64'h40, 64'h55, 7'd101, 7'd2), 1'b0);
		drive(mk_ctx(F_BREAK, 6'd14, 7'd8, 64'h2000, 64'h40, 64'h1a6, 7'd40, 7'd2), 1'b0);
		drain_and_report("break", e0);

		e0 = err_cnt;
		for (int n = 0; n < N_RAND; n++) begin
			rng = xorshift(rng);
			while (rng[2:0] == 3'd0) begin // random stall cycles
				drive(ctx_i, 1'b1);
				rng = xorshift(rng);
			end
			case (rng[31:29] % 7)
				0:       c.status = BUBBLE;
				1:       c.status = F_INIT;
				2, 3:    c.status = F_RUN;
				4:       c.status = F_BREAK;
				5:       c.status = BCK_INI;
				default: c.status = BCK_RUN;
			endcase
			c.read_num = rng[13:8];
			c.ptr_curr = rng[20:14];
			rng = xorshift(rng);
			c.ik.x1 = {32'd0, rng};
			rng = xorshift(rng);
			c.ik.x2 = {48'd0, rng[15:0]};
			c.forward_i = rng[22:16];
			c.min_intv  = rng[29:23];
			rng = xorshift(rng);
			c.ik.x0   = {rng, ~rng};
			c.ik_info = {~rng, rng};
			drive(c, 1'b0);
		end
		drain_and_report("random_stall", e0);

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, bad_tests, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("sim passed");
		end
		else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- fm_extend_properties.sv
module fm_extend_properties (
	input logic                        Clk_32UI,
	input logic                        reset_BWT_extend,
	input logic                        stall_i,
	input fm_extend_pkg::occ_req_t     occ_req_o,
	input logic                        curr_we_o,
	input fm_extend_pkg::curr_wr_t     curr_wr_o,
	input logic                        ret_valid_o,
	input fm_extend_pkg::ret_t         ret_o,
	input fm_extend_pkg::query_req_t   query_o,
	input logic                        dram_valid_o,
	input fm_extend_pkg::dram_req_t    dram_o,
	input fm_extend_pkg::seed_ctx_t    ctx_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import fm_extend_pkg::*;

	//------------------------------------------------------------
	// stall freezes every output
	//------------------------------------------------------------
	a_hold_strobes: assert property (@(posedge Clk_32UI)
		(stall_i && reset_BWT_extend) |=>
			$stable({curr_we_o, ret_valid_o, dram_valid_o}))
		else $error("strobe moved while stalled");

	a_hold_data: assert property (@(posedge Clk_32UI)
		(stall_i && reset_BWT_extend) |=>
			$stable({occ_req_o, curr_wr_o, ret_o, query_o, dram_o, ctx_o}))
		else $error("output data moved while stalled");

	//------------------------------------------------------------
	// strobes quiet out of reset
	//------------------------------------------------------------
	a_reset_strobes: assert property (@(posedge Clk_32UI)
		!reset_BWT_extend |=> (!curr_we_o && !ret_valid_o && !dram_valid_o))
		else $error("strobe high after a reset edge");

endmodule

bind fm_extend_datapath fm_extend_properties u_props (.*);

//--- fm_extend_datapath.sv
module fm_extend_datapath (
	input  logic                            Clk_32UI,
	input  logic                            reset_BWT_extend,
	input  logic                            stall_i,
	input  logic [fm_extend_pkg::CNT_W-1:0] primary_i,  // fixed per index
	input  fm_extend_pkg::seed_ctx_t        ctx_i,
	output fm_extend_pkg::occ_req_t         occ_req_o,  // to the occ engine
	input  fm_extend_pkg::fm_interval_t     occ_rsp_i,  // OCC_LATENCY edges later
	output logic                            curr_we_o,
	output fm_extend_pkg::curr_wr_t         curr_wr_o,
	output logic                            ret_valid_o,
	output fm_extend_pkg::ret_t             ret_o,
	output fm_extend_pkg::query_req_t       query_o,
	output logic                            dram_valid_o,
	output fm_extend_pkg::dram_req_t        dram_o,
	output fm_extend_pkg::seed_ctx_t        ctx_o
);
	import fm_extend_pkg::*;

	seed_ctx_t entry_ctx; // entry stage to delay line
	seed_ctx_t buf_ctx;   // delay line to resolve

	//----------------------------------------------------------
	// entry, Len check and occ request
	//----------------------------------------------------------
	seed_entry_stage u_entry (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.ctx_i            (ctx_i),
		.occ_req_o        (occ_req_o),
		.ctx_o            (entry_ctx)
	);

	//----------------------------------------------------------
	// context wait while the engine counts
	//----------------------------------------------------------
	ctx_delay_line #(
		.DEPTH (CTX_DEPTH)
	) u_delay (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.ctx_i            (entry_ctx),
		.ctx_o            (buf_ctx)
	);

	//----------------------------------------------------------
	// resolve, queue write, return, next query, DRAM fetch
	//----------------------------------------------------------
	extend_resolve u_resolve (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.ctx_i            (buf_ctx),
		.occ_rsp_i        (occ_rsp_i),
		.curr_we_o        (curr_we_o),
		.curr_wr_o        (curr_wr_o),
		.ret_valid_o      (ret_valid_o),
		.ret_o            (ret_o),
		.query_o          (query_o),
		.dram_valid_o     (dram_valid_o),
		.dram_o           (dram_o),
		.ctx_o            (ctx_o)
	);

endmodule

//--- extend_resolve.sv
module extend_resolve (
	input  logic                            Clk_32UI,
	input  logic                            reset_BWT_extend,
	input  logic                            stall_i,
	input  logic [fm_extend_pkg::CNT_W-1:0] primary_i,
	input  fm_extend_pkg::seed_ctx_t        ctx_i,
	input  fm_extend_pkg::fm_interval_t     occ_rsp_i,
	output logic                            curr_we_o,
	output fm_extend_pkg::curr_wr_t         curr_wr_o,
	output logic                            ret_valid_o,
	output fm_extend_pkg::ret_t             ret_o,
	output fm_extend_pkg::query_req_t       query_o,
	output logic                            dram_valid_o,
	output fm_extend_pkg::dram_req_t        dram_o,
	output fm_extend_pkg::seed_ctx_t        ctx_o
);
	import fm_extend_pkg::*;

	logic             x2_changed;  // extension hit a new interval
	logic             x2_below;    // new interval too small
	logic             fwd_at_len;
	seed_ctx_t        dec_ctx;
	logic             dec_we;
	logic             dec_ret_valid;
	ret_t             dec_ret;
	seed_ctx_t        d_ctx;       // decide stage
	fm_interval_t     d_rsp;
	seed_ctx_t        upd_ctx;
	logic [CNT_W-1:0] k_base;
	logic [CNT_W-1:0] l_base;
	seed_ctx_t        u_ctx;       // update stage
	logic [CNT_W-1:0] u_k;
	logic [CNT_W-1:0] u_l;
	logic [CNT_W-1:0] u_k_m;       // minus one, for the primary skip
	logic [CNT_W-1:0] u_l_m;
	seed_ctx_t        h_ctx;       // hold stage
	logic [CNT_W-1:0] h_k;
	logic [CNT_W-1:0] h_l;
	logic [CNT_W-1:0] h_k_m;
	logic [CNT_W-1:0] h_l_m;
	logic [CNT_W-1:0] k_sel;
	logic [CNT_W-1:0] l_sel;

	//----------------------------------------------------------
	// decide
	//----------------------------------------------------------
	always_comb begin
		x2_changed = (occ_rsp_i.x2 != ctx_i.ik.x2);
		x2_below   = (occ_rsp_i.x2 < CNT_W'(ctx_i.min_intv));
		fwd_at_len = (ctx_i.forward_i == POS_W'(LEN));
	end

	always_comb begin
		dec_ctx       = ctx_i;
		dec_we        = 1'b0;
		dec_ret_valid = 1'b0;
		dec_ret       = '0;
		case (ctx_i.status)
			F_RUN: begin
				if (x2_changed) begin
					dec_we           = 1'b1; // push the old interval
					dec_ctx.ptr_curr = ctx_i.ptr_curr + 1'b1;
					if (x2_below) begin
						dec_ctx.status = F_BREAK; // ik is kept as it was
					end
				end
			end
			F_BREAK: begin
				if (fwd_at_len) begin
					dec_we           = 1'b1; // seed reached the read end
					dec_ctx.ptr_curr = ctx_i.ptr_curr + 1'b1;
				end
				dec_ret_valid    = 1'b1;
				dec_ret.read_num = ctx_i.read_num;
				dec_ret.ret      = ctx_i.ik_info[POS_W-1:0];
				dec_ctx.status   = BCK_INI; // on to the backward pass
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			d_ctx.status <= BUBBLE;
			curr_we_o    <= 1'b0;
			ret_valid_o  <= 1'b0;
		end
		else if (!stall_i) begin
			d_ctx              <= dec_ctx;
			d_rsp              <= occ_rsp_i;
			curr_we_o          <= dec_we;
			curr_wr_o.read_num <= ctx_i.read_num;
			curr_wr_o.addr     <= ctx_i.ptr_curr; // old pointer
			curr_wr_o.data     <= {ctx_i.ik_info, ctx_i.ik.x2, ctx_i.ik.x1, ctx_i.ik.x0};
			ret_valid_o        <= dec_ret_valid;
			ret_o              <= dec_ret;
		end
	end

	//----------------------------------------------------------
	// update, ik = ok and i++
	//----------------------------------------------------------
	always_comb begin
		upd_ctx = d_ctx;
		if (d_ctx.status == F_RUN) begin
			upd_ctx.ik        = d_rsp;
			upd_ctx.ik_info   = CNT_W'(d_ctx.forward_i) + 1'b1;
			upd_ctx.forward_i = d_ctx.forward_i + 1'b1;
		end
		k_base = upd_ctx.ik.x1 - 1'b1;
		l_base = k_base + upd_ctx.ik.x2;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			u_ctx.status <= BUBBLE;
		end
		else if (!stall_i) begin
			u_ctx <= upd_ctx;
			u_k   <= k_base;
			u_l   <= l_base;
			u_k_m <= k_base - 1'b1;
			u_l_m <= l_base - 1'b1;
		end
	end

	//----------------------------------------------------------
	// hold, query request one edge before the DRAM issue
	//----------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			h_ctx.status   <= BUBBLE;
			query_o.status <= BUBBLE;
		end
		else if (!stall_i) begin
			h_ctx            <= u_ctx;
			h_k              <= u_k;
			h_l              <= u_l;
			h_k_m            <= u_k_m;
			h_l_m            <= u_l_m;
			query_o.status   <= u_ctx.status;
			query_o.read_num <= u_ctx.read_num;
			query_o.pos      <= u_ctx.forward_i; // byte for the next round
		end
	end

	//----------------------------------------------------------
	// issue
	//----------------------------------------------------------
	always_comb begin
		k_sel = (h_k >= primary_i) ? h_k_m : h_k;
		l_sel = (h_l >= primary_i) ? h_l_m : h_l;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			dram_valid_o <= 1'b0;
			ctx_o.status <= BUBBLE;
		end
		else if (!stall_i) begin
			if (h_ctx.status == F_INIT || h_ctx.status == F_RUN) begin
				dram_valid_o  <= 1'b1; // fetch both occ lines
				dram_o.addr_k <= {k_sel[LINE_MSB:LINE_LSB], 4'b0};
				dram_o.addr_l <= {l_sel[LINE_MSB:LINE_LSB], 4'b0};
			end
			else begin
				dram_valid_o <= 1'b0; // break or backward, no fetch
				dram_o       <= '0;
			end
			ctx_o <= h_ctx;
			if (h_ctx.status == F_INIT) begin
				ctx_o.status <= F_RUN; // init done, extension starts
			end
		end
	end

endmodule

//--- ctx_delay_line.sv
module ctx_delay_line #(
	parameter int DEPTH = fm_extend_pkg::CTX_DEPTH
) (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  fm_extend_pkg::seed_ctx_t ctx_i,
	output fm_extend_pkg::seed_ctx_t ctx_o
);
	import fm_extend_pkg::*;

	seed_ctx_t stage_q [DEPTH]; // stage 0 is the youngest

	//----------------------------------------------------------
	// shift register, frozen as a whole under stall
	//----------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i].status <= BUBBLE; // every slot empty
			end
		end
		else if (!stall_i) begin
			stage_q[0] <= ctx_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign ctx_o = stage_q[DEPTH-1]; // lines up with the occ response

endmodule

//--- seed_entry_stage.sv
module seed_entry_stage (
	input  logic                            Clk_32UI,
	input  logic                            reset_BWT_extend,
	input  logic                            stall_i,
	input  logic [fm_extend_pkg::CNT_W-1:0] primary_i,
	input  fm_extend_pkg::seed_ctx_t        ctx_i,
	output fm_extend_pkg::occ_req_t         occ_req_o,
	output fm_extend_pkg::seed_ctx_t        ctx_o
);
	import fm_extend_pkg::*;

	logic [CNT_W-1:0] k_raw;   // x1 - 1
	logic [CNT_W-1:0] l_raw;   // k + x2
	logic [CNT_W-1:0] k_adj;
	logic [CNT_W-1:0] l_adj;
	seed_ctx_t        ctx_nxt;

	//----------------------------------------------------------
	// occurrence request
	//----------------------------------------------------------
	always_comb begin
		k_raw = ctx_i.ik.x1 - 1'b1;
		l_raw = k_raw + ctx_i.ik.x2;
		k_adj = (k_raw >= primary_i) ? k_raw - 1'b1 : k_raw; // skip the $ row
		l_adj = (l_raw >= primary_i) ? l_raw - 1'b1 : l_raw;
	end

	//----------------------------------------------------------
	// length limit
	//----------------------------------------------------------
	always_comb begin
		ctx_nxt = ctx_i;
		if (ctx_i.status == F_RUN && ctx_i.forward_i >= LEN) begin
			ctx_nxt.status = F_BREAK; // ran off the end of the read
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx_o.status <= BUBBLE;
		end
		else if (!stall_i) begin
			ctx_o <= ctx_nxt;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			occ_req_o.k <= k_adj; // engine sees it next edge
			occ_req_o.l <= l_adj;
		end
	end

endmodule

//--- fm_extend_pkg.sv
package fm_extend_pkg;

	//----------------------------------------------------------
	// widths and depths
	//----------------------------------------------------------
	localparam int READ_NUM_W  = 6;              // read slot index
	localparam int POS_W       = 7;              // query position, forward_i, min_intv
	localparam int CNT_W       = 64;             // one suffix-array interval word
	localparam int LEN         = 101;            // query length
	localparam int CTX_DEPTH   = 12;             // context stages alongside the occ engine
	localparam int OCC_LATENCY = CTX_DEPTH + 1;  // request edge to sampled response
	localparam int ADDR_W      = 32;             // DRAM line address
	localparam int LINE_MSB    = 34;             // top bit of the line index
	localparam int LINE_LSB    = 7;              // 128-byte occ lines
	localparam int CURR_DATA_W = 4 * CNT_W;      // info, x2, x1, x0

	//----------------------------------------------------------
	// status codes, one-hot
	//----------------------------------------------------------
	typedef enum logic [5:0] {
		BUBBLE  = 6'b00_0000, // empty slot
		F_INIT  = 6'b00_0001, // first pass, only fetches the occ lines
		F_RUN   = 6'b00_0010, // forward extension running
		F_BREAK = 6'b00_0100, // forward done, report the end position
		BCK_INI = 6'b00_1000, // handed to the backward pass
		BCK_RUN = 6'b01_0000,
		BCK_END = 6'b10_0000
	} status_t;

	//----------------------------------------------------------
	// payload structs
	//----------------------------------------------------------
	typedef struct packed {
		logic [CNT_W-1:0] x2; // interval size
		logic [CNT_W-1:0] x1; // start on the forward strand
		logic [CNT_W-1:0] x0; // start on the reverse strand
	} fm_interval_t;

	typedef struct packed {
		status_t               status;
		logic [POS_W-1:0]      ptr_curr;  // next free slot in the curr queue
		logic [READ_NUM_W-1:0] read_num;
		fm_interval_t          ik;
		logic [CNT_W-1:0]      ik_info;   // end position of the seed so far
		logic [POS_W-1:0]      forward_i; // next query position
		logic [POS_W-1:0]      min_intv;
	} seed_ctx_t;

	typedef struct packed {
		logic [CNT_W-1:0] k;
		logic [CNT_W-1:0] l;
	} occ_req_t;

	typedef struct packed {
		logic [READ_NUM_W-1:0]  read_num;
		logic [POS_W-1:0]       addr;
		logic [CURR_DATA_W-1:0] data; // {info, x2, x1, x0}
	} curr_wr_t;

	typedef struct packed {
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0]      ret;
	} ret_t;

	typedef struct packed {
		status_t               status;
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0]      pos; // query byte to fetch next
	} query_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr_k;
		logic [ADDR_W-1:0] addr_l;
	} dram_req_t;

endpackage
